/* flist.f */
+incdir+common
common/soc_pkg.sv
verilog/bus_arbiter.sv
verilog/bus_fabric.sv
verilog/sync_sram.sv
timer/machine_timer.sv
verilog/soc_top.sv
tests/soc_checker.sv
tests/tb_soc.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the soc testbench with verilator and run it from the project root
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module tb_soc -f flist.f --Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_soc +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Verification failed" "$log"; then
	exit 1
fi
exit 0

/* tests/soc_stimulus.txt */
# master (0 cpu, 1 dbg), op, address, wdata, expected rdata, expected err, all hex
# op: 0 read, 1 write, 2 read and keep, 3 read expecting a larger value than kept,
# 4 idle for wdata cycles, 5 wait for timer_irq equal to expected rdata
0 1 000003FC 5A5AC3C3 00000000 0
0 1 00000010 DEADBEEF 00000000 0
0 0 00000010 00000000 DEADBEEF 0
0 1 00000124 12345678 00000000 0
1 0 00000124 00000000 12345678 0
1 1 00000040 CAFEF00D 00000000 0
0 0 00000040 00000000 CAFEF00D 0
0 0 80000000 00000000 00000000 1
0 0 00000010 00000000 DEADBEEF 0
1 1 00000410 0BADF00D 00000000 0
0 0 00000010 00000000 0BADF00D 0
0 1 40000000 00000001 00000000 0
0 0 40000000 00000000 00000001 0
0 5 00000000 00000000 00000000 0
0 2 40000008 00000000 00000000 0
0 4 00000000 000001F4 00000000 0
0 3 40000008 00000000 00000000 0
0 1 40000010 00000000 00000000 0
0 1 40000014 00000000 00000000 0
0 5 00000000 00000000 00000001 0
0 1 40000010 FFFFFFFF 00000000 0
0 1 40000014 FFFFFFFF 00000000 0
0 5 00000000 00000000 00000000 0

/* tests/tb_soc.sv */
`timescale 1ns/1ps

module tb_soc;
	import soc_pkg::*;

	localparam int ACC_TIMEOUT = 40;
	localparam int IRQ_TIMEOUT = 400;
	// rdy two cycles after an idle grant
	localparam int LAT_FIRST = 2;
	// cpu sits out dbg's access and the cycle until dbg drops vld
	localparam int LAT_BEHIND = 2 * LAT_FIRST + 1;
	localparam addr_t SCRATCH_ADDR = 32'h0000_03FC;

	localparam logic [3:0] OP_RD   = 4'h0;
	localparam logic [3:0] OP_WR   = 4'h1;
	localparam logic [3:0] OP_SAVE = 4'h2;
	localparam logic [3:0] OP_GROW = 4'h3;
	localparam logic [3:0] OP_IDLE = 4'h4;
	localparam logic [3:0] OP_IRQ  = 4'h5;

	logic  clk;
	logic  rst_n;
	logic  cpu_vld;
	logic  cpu_write;
	addr_t cpu_addr;
	data_t cpu_wdata;
	logic  cpu_rdy;
	data_t cpu_rdata;
	logic  cpu_err;
	logic  dbg_vld;
	logic  dbg_write;
	addr_t dbg_addr;
	data_t dbg_wdata;
	logic  dbg_rdy;
	data_t dbg_rdata;
	logic  dbg_err;
	logic  timer_irq;

	int          errors;
	int          timeouts;
	logic [15:0] lfsr;
	data_t       saved;
	data_t       scratch_val;
	logic        scratch_ok;

	soc_top u_soc_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.cpu_vld   (cpu_vld),
		.cpu_write (cpu_write),
		.cpu_addr  (cpu_addr),
		.cpu_wdata (cpu_wdata),
		.cpu_rdy   (cpu_rdy),
		.cpu_rdata (cpu_rdata),
		.cpu_err   (cpu_err),
		.dbg_vld   (dbg_vld),
		.dbg_write (dbg_write),
		.dbg_addr  (dbg_addr),
		.dbg_wdata (dbg_wdata),
		.dbg_rdy   (dbg_rdy),
		.dbg_rdata (dbg_rdata),
		.dbg_err   (dbg_err),
		.timer_irq (timer_irq)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ----------------------------------------
	// helpers

	// galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// space, tab, newline, carriage return
	function automatic logic is_blank(input int c);
		return c == 32 || c == 9 || c == 10 || c == 13;
	endfunction

	task automatic check_value(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic end_run();
		int asrt;
		asrt = u_soc_top.u_bus_arbiter.u_soc_checker.fail_cnt;
		$display("errors: %0d checks, %0d timeouts, %0d assertions", errors, timeouts, asrt);
		if (errors == 0 && timeouts == 0 && asrt == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	endtask

	// one access on one port, lat counts falling edges until rdy
	task automatic bus_access(input logic on_dbg, input logic wr, input addr_t addr,
			input data_t wdata, output data_t rdata, output logic err, output int lat);
		logic seen;
		seen  = 1'b0;
		lat   = 0;
		rdata = '0;
		err   = 1'b0;
		@(negedge clk);
		if (on_dbg) begin
			dbg_vld   = 1'b1;
			dbg_write = wr;
			dbg_addr  = addr;
			dbg_wdata = wdata;
		end else begin
			cpu_vld   = 1'b1;
			cpu_write = wr;
			cpu_addr  = addr;
			cpu_wdata = wdata;
		end
		while (!seen && lat < ACC_TIMEOUT) begin
			@(negedge clk);
			lat++;
			if (on_dbg ? dbg_rdy : cpu_rdy) begin
				seen  = 1'b1;
				rdata = on_dbg ? dbg_rdata : cpu_rdata;
				err   = on_dbg ? dbg_err : cpu_err;
			end
		end
		if (!seen) begin
			$display("no %s_rdy within %0d cycles of raising vld",
				on_dbg ? "dbg" : "cpu", ACC_TIMEOUT);
			timeouts++;
		end
		// vld stays up through the rdy edge
		@(negedge clk);
		if (on_dbg) begin
			dbg_vld = 1'b0;
		end else begin
			cpu_vld = 1'b0;
		end
	endtask

	// ----------------------------------------
	// one stimulus line

	task automatic run_line(input logic dbg_main, input logic [3:0] op, input addr_t addr,
			input data_t wdata, input data_t exp, input logic exp_err, input logic take);
		data_t rdata;
		data_t ov_rdata;
		logic  err;
		logic  ov_err;
		int    lat;
		int    ov_lat;
		int    cnt;
		string pfx;
		string ov_pfx;
		logic  overlap;
		pfx     = dbg_main ? "dbg" : "cpu";
		ov_pfx  = dbg_main ? "cpu" : "dbg";
		overlap = take && scratch_ok;
		case (op)
			OP_IDLE: begin
				for (cnt = 0; cnt < int'(wdata); cnt++) begin
					@(negedge clk);
				end
			end
			OP_IRQ: begin
				cnt = 0;
				while (timer_irq !== exp[0] && cnt < IRQ_TIMEOUT) begin
					@(negedge clk);
					cnt++;
				end
				if (timer_irq !== exp[0]) begin
					$display("timer_irq did not reach %0d within %0d cycles", exp[0], IRQ_TIMEOUT);
					timeouts++;
				end
			end
			default: begin
				if (overlap) begin
					// the other master reads the scratch word at the same time
					fork
						bus_access(dbg_main, op == OP_WR, addr, wdata, rdata, err, lat);
						bus_access(!dbg_main, 1'b0, SCRATCH_ADDR, '0, ov_rdata, ov_err, ov_lat);
					join
					check_value({ov_pfx, "_rdata"}, ov_rdata, scratch_val);
					check_value({ov_pfx, "_err"}, data_t'(ov_err), '0);
					check_value({ov_pfx, "_rdy latency"}, ov_lat,
						dbg_main ? LAT_BEHIND : LAT_FIRST);
				end else begin
					bus_access(dbg_main, op == OP_WR, addr, wdata, rdata, err, lat);
				end
				check_value({pfx, "_rdy latency"}, lat,
					(overlap && !dbg_main) ? LAT_BEHIND : LAT_FIRST);
				check_value({pfx, "_err"}, data_t'(err), data_t'(exp_err));
				case (op)
					OP_RD: check_value({pfx, "_rdata"}, rdata, exp);
					OP_SAVE: saved = rdata;
					OP_GROW: begin
						if (!(rdata > saved)) begin
							$display("[FAIL] %s_rdata: got %h expected above %h",
								pfx, rdata, saved);
							errors++;
						end
					end
					default: begin
						if (addr == SCRATCH_ADDR) begin
							scratch_val = wdata;
							scratch_ok  = 1'b1;
						end
					end
				endcase
			end
		endcase
	endtask

	// ----------------------------------------
	// main sequence

	initial begin
		int               fd;
		int               c;
		int               n;
		logic             done;
		logic             take;
		logic             dbg_main;
		logic [3:0]       op;
		addr_t            addr;
		data_t            wdata;
		data_t            exp;
		logic             exp_err;
		logic [8*160-1:0] skip_line;

		errors      = 0;
		timeouts    = 0;
		lfsr        = 16'd43;
		saved       = '0;
		scratch_val = '0;
		scratch_ok  = 1'b0;
		cpu_vld     = 1'b0;
		cpu_write   = 1'b0;
		cpu_addr    = '0;
		cpu_wdata   = '0;
		dbg_vld     = 1'b0;
		dbg_write   = 1'b0;
		dbg_addr    = '0;
		dbg_wdata   = '0;
		rst_n       = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		fd = $fopen("tests/soc_stimulus.txt", "r");
		if (fd == 0) begin
			$display("cannot open tests/soc_stimulus.txt");
			errors++;
		end else begin
			done = 1'b0;
			while (!done) begin
				c = $fgetc(fd);
				// skip blanks and comment lines
				while (c == int'("#") || is_blank(c)) begin
					if (c == int'("#")) begin
						n = $fgets(skip_line, fd);
					end
					c = $fgetc(fd);
				end
				if (c == -1) begin
					done = 1'b1;
				end else begin
					dbg_main = (c == int'("1"));
					n = $fscanf(fd, " %h %h %h %h %h", op, addr, wdata, exp, exp_err);
					if (n != 5) begin
						$display("malformed line in tests/soc_stimulus.txt");
						errors++;
						done = 1'b1;
					end else begin
						take = lfsr[0];
						lfsr = lfsr_next(lfsr);
						run_line(dbg_main, op, addr, wdata, exp, exp_err, take);
						// a stuck access ends the sequence
						if (timeouts != 0) begin
							done = 1'b1;
						end
					end
				end
			end
			$fclose(fd);
		end
		repeat (4) @(negedge clk);
		end_run();
	end

endmodule

/* tests/soc_checker.sv */
`timescale 1ns/1ps

module soc_checker (
	input logic clk,
	input logic rst_n,
	input logic cpu_vld,
	input logic dbg_vld,
	input logic cpu_rdy,
	input logic dbg_rdy,
	input logic bus_req
);

	// failed assertion count
	int fail_cnt = 0;

	// ----------------------------------------
	// one response at a time

	rdy_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(cpu_rdy && dbg_rdy))
		else begin
			$error("cpu_rdy and dbg_rdy high in the same cycle");
			fail_cnt++;
		end

	// rdy only toward a master that still requests
	cpu_rdy_vld: assert property (@(posedge clk) disable iff (!rst_n) cpu_rdy |-> cpu_vld)
		else begin
			$error("cpu_rdy without cpu_vld");
			fail_cnt++;
		end

	dbg_rdy_vld: assert property (@(posedge clk) disable iff (!rst_n) dbg_rdy |-> dbg_vld)
		else begin
			$error("dbg_rdy without dbg_vld");
			fail_cnt++;
		end

	// ----------------------------------------
	// every rdy follows a bus_req by two cycles

	req_to_rdy: assert property (@(posedge clk) disable iff (!rst_n)
		(cpu_rdy || dbg_rdy) == $past(bus_req, 2))
		else begin
			$error("rdy not two cycles after bus_req");
			fail_cnt++;
		end

endmodule

bind bus_arbiter soc_checker u_soc_checker (
	.clk     (clk),
	.rst_n   (rst_n),
	.cpu_vld (cpu_vld),
	.dbg_vld (dbg_vld),
	.cpu_rdy (cpu_rdy),
	.dbg_rdy (dbg_rdy),
	.bus_req (bus_req)
);

/* verilog/soc_top.sv */
`timescale 1ns/1ps
`include "soc_defs.svh"

module soc_top (
	input  logic           clk,
	input  logic           rst_n,

	// processor port
	input  logic           cpu_vld,
	input  logic           cpu_write,
	input  soc_pkg::addr_t cpu_addr,
	input  soc_pkg::data_t cpu_wdata,
	output logic           cpu_rdy,
	output soc_pkg::data_t cpu_rdata,
	output logic           cpu_err,

	// debug system bus port
	input  logic           dbg_vld,
	input  logic           dbg_write,
	input  soc_pkg::addr_t dbg_addr,
	input  soc_pkg::data_t dbg_wdata,
	output logic           dbg_rdy,
	output soc_pkg::data_t dbg_rdata,
	output logic           dbg_err,

	output logic           timer_irq
);
	import soc_pkg::*;

	// ----------------------------------------
	// internal bus

	logic  bus_req;
	logic  bus_write;
	addr_t bus_addr;
	data_t bus_wdata;
	data_t bus_rdata;
	logic  bus_err;

	// target side
	logic                          sram_en;
	logic                          sram_we;
	logic [$clog2(`SRAM_DEPTH)-1:0] sram_index;
	data_t                         sram_wdata;
	data_t                         sram_rdata;

	logic       tmr_en;
	logic       tmr_we;
	logic [4:0] tmr_ofs;
	data_t      tmr_wdata;
	data_t      tmr_rdata;

	bus_arbiter u_bus_arbiter (
		.clk       (clk),
		.rst_n     (rst_n),
		.cpu_vld   (cpu_vld),
		.cpu_write (cpu_write),
		.cpu_addr  (cpu_addr),
		.cpu_wdata (cpu_wdata),
		.cpu_rdy   (cpu_rdy),
		.cpu_rdata (cpu_rdata),
		.cpu_err   (cpu_err),
		.dbg_vld   (dbg_vld),
		.dbg_write (dbg_write),
		.dbg_addr  (dbg_addr),
		.dbg_wdata (dbg_wdata),
		.dbg_rdy   (dbg_rdy),
		.dbg_rdata (dbg_rdata),
		.dbg_err   (dbg_err),
		.bus_req   (bus_req),
		.bus_write (bus_write),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.bus_rdata (bus_rdata),
		.bus_err   (bus_err)
	);

	bus_fabric u_bus_fabric (
		.clk        (clk),
		.rst_n      (rst_n),
		.bus_req    (bus_req),
		.bus_write  (bus_write),
		.bus_addr   (bus_addr),
		.bus_wdata  (bus_wdata),
		.bus_rdata  (bus_rdata),
		.bus_err    (bus_err),
		.sram_en    (sram_en),
		.sram_we    (sram_we),
		.sram_index (sram_index),
		.sram_wdata (sram_wdata),
		.sram_rdata (sram_rdata),
		.tmr_en     (tmr_en),
		.tmr_we     (tmr_we),
		.tmr_ofs    (tmr_ofs),
		.tmr_wdata  (tmr_wdata),
		.tmr_rdata  (tmr_rdata)
	);

	sync_sram u_sync_sram (
		.clk   (clk),
		.en    (sram_en),
		.we    (sram_we),
		.index (sram_index),
		.wdata (sram_wdata),
		.rdata (sram_rdata)
	);

	machine_timer u_machine_timer (
		.clk       (clk),
		.rst_n     (rst_n),
		.en        (tmr_en),
		.we        (tmr_we),
		.ofs       (tmr_ofs),
		.wdata     (tmr_wdata),
		.rdata     (tmr_rdata),
		.timer_irq (timer_irq)
	);

endmodule

/* timer/machine_timer.sv */
`timescale 1ns/1ps
`include "soc_defs.svh"

module machine_timer (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           en,
	input  logic           we,
	input  logic [4:0]     ofs,
	input  soc_pkg::data_t wdata,
	output soc_pkg::data_t rdata,
	output logic           timer_irq
);
	import soc_pkg::*;

	localparam int TICK_W = $clog2(`SOC_CLK_MHZ + 1);

	logic [TICK_W-1:0] tick_ctr;
	logic              tick;
	logic              ctrl_en;
	logic [63:0]       mtime;
	logic [63:0]       mtimecmp;
	logic              wr;
	data_t             rd_mux;

	assign wr = en && we;

	// ----------------------------------------
	// microsecond tick

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tick_ctr <= '0;
			tick     <= 1'b0;
		end else begin
			if (tick_ctr != '0) begin
				tick_ctr <= tick_ctr - 1'b1;
			end else begin
				tick_ctr <= TICK_W'(`SOC_CLK_MHZ - 1);
			end
			tick <= (tick_ctr == '0);
		end
	end

	// ----------------------------------------
	// registers

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_en  <= 1'b0;
			mtime    <= '0;
			mtimecmp <= '1;
		end else begin
			if (wr && ofs == `TIMER_CTRL_OFS) begin
				ctrl_en <= wdata[0];
			end
			// bus write wins over the count
			if (wr && ofs == `TIMER_MTIME_LO_OFS) begin
				mtime[31:0] <= wdata;
			end else if (wr && ofs == `TIMER_MTIME_HI_OFS) begin
				mtime[63:32] <= wdata;
			end else if (tick && ctrl_en) begin
				mtime <= mtime + 64'd1;
			end
			if (wr && ofs == `TIMER_CMP_LO_OFS) begin
				mtimecmp[31:0] <= wdata;
			end
			if (wr && ofs == `TIMER_CMP_HI_OFS) begin
				mtimecmp[63:32] <= wdata;
			end
		end
	end

	// unknown offsets read zero
	always_comb begin
		case (ofs)
			`TIMER_CTRL_OFS:     rd_mux = {{(`SOC_DATA_W-1){1'b0}}, ctrl_en};
			`TIMER_MTIME_LO_OFS: rd_mux = mtime[31:0];
			`TIMER_MTIME_HI_OFS: rd_mux = mtime[63:32];
			`TIMER_CMP_LO_OFS:   rd_mux = mtimecmp[31:0];
			`TIMER_CMP_HI_OFS:   rd_mux = mtimecmp[63:32];
			default:             rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (en && !we) begin
			rdata <= rd_mux;
		end
	end

	// level interrupt
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			timer_irq <= 1'b0;
		end else begin
			timer_irq <= ctrl_en && (mtime >= mtimecmp);
		end
	end

endmodule

/* verilog/sync_sram.sv */
`timescale 1ns/1ps
`include "soc_defs.svh"

module sync_sram (
	input  logic                           clk,
	input  logic                           en,
	input  logic                           we,
	input  logic [$clog2(`SRAM_DEPTH)-1:0] index,
	input  soc_pkg::data_t                 wdata,
	output soc_pkg::data_t                 rdata
);
	import soc_pkg::*;

	// word array
	data_t mem [`SRAM_DEPTH];

	// ----------------------------------------
	// single port, read before write

	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[index] <= wdata;
			end
			rdata <= mem[index];
		end
	end

endmodule

/* verilog/bus_fabric.sv */
`timescale 1ns/1ps
`include "soc_defs.svh"

module bus_fabric (
	input  logic                           clk,
	input  logic                           rst_n,

	input  logic                           bus_req,
	input  logic                           bus_write,
	input  soc_pkg::addr_t                 bus_addr,
	input  soc_pkg::data_t                 bus_wdata,
	output soc_pkg::data_t                 bus_rdata,
	output logic                           bus_err,

	output logic                           sram_en,
	output logic                           sram_we,
	output logic [$clog2(`SRAM_DEPTH)-1:0] sram_index,
	output soc_pkg::data_t                 sram_wdata,
	input  soc_pkg::data_t                 sram_rdata,

	output logic                           tmr_en,
	output logic                           tmr_we,
	output logic [4:0]                     tmr_ofs,
	output soc_pkg::data_t                 tmr_wdata,
	input  soc_pkg::data_t                 tmr_rdata
);
	import soc_pkg::*;

	localparam int IDX_W = $clog2(`SRAM_DEPTH);

	region_t region;
	region_t region_q;
	logic    req_q;

	// ----------------------------------------
	// decode

	always_comb begin
		if ((bus_addr & `REGION_MASK) == `SRAM_BASE) begin
			region = region_sram;
		end else if ((bus_addr & `REGION_MASK) == `TIMER_BASE) begin
			region = region_timer;
		end else begin
			region = region_none;
		end
	end

	// word index, upper bits wrap
	assign sram_en    = bus_req && (region == region_sram);
	assign sram_we    = sram_en && bus_write;
	assign sram_index = bus_addr[2 +: IDX_W];
	assign sram_wdata = bus_wdata;

	assign tmr_en    = bus_req && (region == region_timer);
	assign tmr_we    = tmr_en && bus_write;
	assign tmr_ofs   = bus_addr[4:0];
	assign tmr_wdata = bus_wdata;

	// ----------------------------------------
	// response, one cycle after bus_req

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req_q    <= 1'b0;
			region_q <= region_none;
		end else begin
			req_q <= bus_req;
			if (bus_req) begin
				region_q <= region;
			end
		end
	end

	always_comb begin
		case (region_q)
			region_sram:  bus_rdata = sram_rdata;
			region_timer: bus_rdata = tmr_rdata;
			default:      bus_rdata = '0;
		endcase
	end

	assign bus_err = req_q && (region_q == region_none);

endmodule

/* verilog/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter (
	input  logic           clk,
	input  logic           rst_n,

	input  logic           cpu_vld,
	input  logic           cpu_write,
	input  soc_pkg::addr_t cpu_addr,
	input  soc_pkg::data_t cpu_wdata,
	output logic           cpu_rdy,
	output soc_pkg::data_t cpu_rdata,
	output logic           cpu_err,

	input  logic           dbg_vld,
	input  logic           dbg_write,
	input  soc_pkg::addr_t dbg_addr,
	input  soc_pkg::data_t dbg_wdata,
	output logic           dbg_rdy,
	output soc_pkg::data_t dbg_rdata,
	output logic           dbg_err,

	output logic           bus_req,
	output logic           bus_write,
	output soc_pkg::addr_t bus_addr,
	output soc_pkg::data_t bus_wdata,
	input  soc_pkg::data_t bus_rdata,
	input  logic           bus_err
);
	import soc_pkg::*;

	typedef enum logic {
		st_idle,
		st_wait_resp
	} state_t;

	state_t  state;
	master_t grant;
	master_t pick;
	data_t   rdata_q;
	logic    err_q;
	logic    resp_done;

	// ----------------------------------------
	// request side, dbg has fixed priority

	assign pick      = dbg_vld ? master_dbg : master_cpu;
	assign bus_req   = (state == st_idle) && (cpu_vld || dbg_vld);
	assign bus_write = (pick == master_dbg) ? dbg_write : cpu_write;
	assign bus_addr  = (pick == master_dbg) ? dbg_addr : cpu_addr;
	assign bus_wdata = (pick == master_dbg) ? dbg_wdata : cpu_wdata;

	// rdy already out, leave wait_resp on this edge
	assign resp_done = cpu_rdy || dbg_rdy;

	// ----------------------------------------
	// sequencer

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= st_idle;
			grant   <= master_cpu;
			cpu_rdy <= 1'b0;
			dbg_rdy <= 1'b0;
			err_q   <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (bus_req) begin
						state <= st_wait_resp;
						grant <= pick;
					end
				end
				st_wait_resp: begin
					if (resp_done) begin
						cpu_rdy <= 1'b0;
						dbg_rdy <= 1'b0;
						err_q   <= 1'b0;
						state   <= st_idle;
					end else begin
						// fabric answer is valid this cycle
						cpu_rdy <= (grant == master_cpu);
						dbg_rdy <= (grant == master_dbg);
						err_q   <= bus_err;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_wait_resp && !resp_done) begin
			rdata_q <= bus_rdata;
		end
	end

	// response only toward the granted master
	assign cpu_rdata = cpu_rdy ? rdata_q : '0;
	assign dbg_rdata = dbg_rdy ? rdata_q : '0;
	assign cpu_err   = cpu_rdy && err_q;
	assign dbg_err   = dbg_rdy && err_q;

endmodule

/* common/soc_pkg.sv */
`include "soc_defs.svh"

package soc_pkg;

	// ----------------------------------------
	// bus payload types

	typedef logic [`SOC_ADDR_W-1:0] addr_t;
	typedef logic [`SOC_DATA_W-1:0] data_t;

	// ----------------------------------------
	// enumerations

	// the two bus masters
	typedef enum logic {
		master_cpu,
		master_dbg
	} master_t;

	// address decode result
	typedef enum logic [1:0] {
		region_sram,
		region_timer,
		region_none
	} region_t;

endpackage

/* common/soc_defs.svh */
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32

// clk rate in MHz, sets the microsecond tick divide
`define SOC_CLK_MHZ 50

// sram size in words
`define SRAM_DEPTH 256

// address map
`define SRAM_BASE   32'h0000_0000
`define TIMER_BASE  32'h4000_0000
`define REGION_MASK 32'hE000_0000

// timer register byte offsets
`define TIMER_CTRL_OFS     5'h00
`define TIMER_MTIME_LO_OFS 5'h08
`define TIMER_MTIME_HI_OFS 5'h0C
`define TIMER_CMP_LO_OFS   5'h10
`define TIMER_CMP_HI_OFS   5'h14

`endif
